// ==== tb.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/access_decode.sv
hdl/data_cache.sv
hdl/mem_stage.sv
hdl/load_align.sv
hdl/lsu_top.sv
test/line_mem_model.sv
test/tb_lsu.sv

// ==== test/tb_lsu.sv ====
`timescale 1ns/1ps

`include "lsu_defines.svh"

module tb_lsu;

  import lsu_pkg::*;

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 10;
  localparam int          MEM_BYTES    = 1024;
  localparam int          GNT_LAT      = 2;
  localparam int          RD_LAT       = 3;
  localparam int          WR_LAT       = 2;
  localparam logic [31:0] FILL_KEY     = 32'h5a3c_96e1;
  localparam logic [31:0] SEED         = 32'd4392;
  localparam int          RAND_OPS     = 200;
  localparam int          OP_BUDGET    = RAND_OPS + 80; // directed ops fit in the margin
  localparam int          MISS_CYCLES  = 2 * (GNT_LAT + 2) + RD_LAT + WR_LAT + 6;
  localparam int          TIMEOUT_NS   = (RESET_CYCLES + OP_BUDGET * (MISS_CYCLES + 3) +
                                          2 * `LSU_N_LINES * MISS_CYCLES + 100) * CLK_PERIOD;

  logic         clk_i;
  logic         rst_i;
  logic         valid_i;
  logic         is_load_i;
  logic         is_store_i;
  logic         is_unsigned_i;
  logic         reg_wr_en_i;
  access_size_t access_size_i;
  addr_t        addr_i;
  word_t        store_data_i;
  reg_idx_t     wr_reg_i;
  logic         stall_o;
  logic         wb_valid_o;
  logic         wb_reg_wr_en_o;
  reg_idx_t     wb_wr_reg_o;
  word_t        wb_data_o;
  logic         rd_req_valid_o;
  logic         wr_req_valid_o;
  addr_t        mem_addr_o;
  line_t        wr_line_o;
  logic         mem_gnt_i;
  logic         mem_rvalid_i;
  line_t        mem_line_i;
  logic         mem_write_done_i;
  logic         flush_i;
  logic         done_o;
  addr_t        peek_addr;
  word_t        peek_data;

  logic [7:0]  shadow  [MEM_BYTES];   // expected memory image
  bit          touched [MEM_BYTES/4]; // words written by a store
  logic [31:0] lcg_state;
  int          error_count;
  int          check_count;

  // results of the last operation
  word_t    last_data;
  logic     last_stall;
  logic     last_reg_wr_en;
  reg_idx_t last_wr_reg;
  logic     last_evict;
  int       last_cycles;

  lsu_top i_lsu_top (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .valid_i          (valid_i),
    .is_load_i        (is_load_i),
    .is_store_i       (is_store_i),
    .is_unsigned_i    (is_unsigned_i),
    .reg_wr_en_i      (reg_wr_en_i),
    .access_size_i    (access_size_i),
    .addr_i           (addr_i),
    .store_data_i     (store_data_i),
    .wr_reg_i         (wr_reg_i),
    .stall_o          (stall_o),
    .wb_valid_o       (wb_valid_o),
    .wb_reg_wr_en_o   (wb_reg_wr_en_o),
    .wb_wr_reg_o      (wb_wr_reg_o),
    .wb_data_o        (wb_data_o),
    .rd_req_valid_o   (rd_req_valid_o),
    .wr_req_valid_o   (wr_req_valid_o),
    .mem_addr_o       (mem_addr_o),
    .wr_line_o        (wr_line_o),
    .mem_gnt_i        (mem_gnt_i),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_line_i       (mem_line_i),
    .mem_write_done_i (mem_write_done_i),
    .flush_i          (flush_i),
    .done_o           (done_o)
  );

  line_mem_model #(
    .MEM_BYTES (MEM_BYTES),
    .GNT_LAT   (GNT_LAT),
    .RD_LAT    (RD_LAT),
    .WR_LAT    (WR_LAT),
    .FILL_KEY  (FILL_KEY)
  ) i_line_mem (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .rd_req_i     (rd_req_valid_o),
    .wr_req_i     (wr_req_valid_o),
    .addr_i       (mem_addr_o),
    .wr_line_i    (wr_line_o),
    .gnt_o        (mem_gnt_i),
    .rvalid_o     (mem_rvalid_i),
    .line_o       (mem_line_i),
    .write_done_o (mem_write_done_i),
    .peek_addr_i  (peek_addr),
    .peek_data_o  (peek_data)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Error: simulation timed out after %0d ns", TIMEOUT_NS);
    $display("Test FAILED");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int size_bytes(input access_size_t sz);
    return (sz == SIZE_BYTE) ? 1 : ((sz == SIZE_HALF) ? 2 : 4);
  endfunction

  function automatic word_t shadow_word(input addr_t a);
    return {shadow[a + 3], shadow[a + 2], shadow[a + 1], shadow[a]};
  endfunction

  // little-endian bytes from the shadow then sign or zero fill
  function automatic word_t expect_load(input access_size_t sz, input addr_t a, input logic uns);
    word_t raw;
    int    n;
    n   = size_bytes(sz);
    raw = '0;
    for (int b = 0; b < n; b++) begin
      raw[b*8 +: 8] = shadow[a + b];
    end
    if (!uns && raw[n*8-1]) begin
      for (int b = n; b < 4; b++) begin
        raw[b*8 +: 8] = 8'hff;
      end
    end
    return raw;
  endfunction

  task automatic shadow_write(input access_size_t sz, input addr_t a, input word_t d);
    int n;
    n = size_bytes(sz);
    for (int b = 0; b < n; b++) begin
      shadow[a + b]        = d[b*8 +: 8];
      touched[(a + b) / 4] = 1'b1;
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    check_count++;
    if (got !== expected) begin
      error_count++;
      $display("Fail at %0d ns: %s, got %h, expected %h", $time, what, got, expected);
    end
  endtask

  // drives one operation until writeback and notes a victim write ahead of the fill
  task automatic run_op(input logic ld, input logic st, input logic uns, input logic wren,
                        input access_size_t sz, input addr_t a, input word_t d,
                        input reg_idx_t rd);
    bit seen_rd;
    seen_rd     = 1'b0;
    last_evict  = 1'b0;
    last_cycles = 0;
    @(posedge clk_i);
    #1;
    valid_i       = 1'b1;
    is_load_i     = ld;
    is_store_i    = st;
    is_unsigned_i = uns;
    reg_wr_en_i   = wren;
    access_size_i = sz;
    addr_i        = a;
    store_data_i  = d;
    wr_reg_i      = rd;
    @(negedge clk_i);
    while (!wb_valid_o) begin
      check_value("stall held during miss", stall_o, 1);
      if (rd_req_valid_o) begin
        seen_rd = 1'b1;
      end
      if (wr_req_valid_o && !seen_rd) begin
        last_evict = 1'b1;
      end
      last_cycles++;
      @(negedge clk_i);
    end
    last_data      = wb_data_o;
    last_stall     = stall_o;
    last_reg_wr_en = wb_reg_wr_en_o;
    last_wr_reg    = wb_wr_reg_o;
    @(posedge clk_i);
    #1;
    valid_i    = 1'b0;
    is_load_i  = 1'b0;
    is_store_i = 1'b0;
  endtask

  task automatic load_and_check(input access_size_t sz, input addr_t a, input logic uns);
    reg_idx_t rd;
    rd = reg_idx_t'(lcg_next() >> 27);
    run_op(1'b1, 1'b0, uns, 1'b1, sz, a, '0, rd);
    check_value($sformatf("load %h size %0d unsigned %0b", a, sz, uns), last_data,
                expect_load(sz, a, uns));
    check_value("load register write enable", last_reg_wr_en, 1);
    check_value("load destination register", last_wr_reg, rd);
    check_value("stall at load writeback", last_stall, 0);
  endtask

  task automatic store_and_update(input access_size_t sz, input addr_t a, input word_t d);
    reg_idx_t rd;
    rd = reg_idx_t'(lcg_next() >> 27);
    run_op(1'b0, 1'b1, 1'b0, 1'b0, sz, a, d, rd);
    shadow_write(sz, a, d);
    check_value("store register write enable", last_reg_wr_en, 0);
    check_value("stall at store writeback", last_stall, 0);
  endtask

  task automatic flush_and_compare();
    @(posedge clk_i);
    #1;
    flush_i = 1'b1;
    @(negedge clk_i);
    while (!done_o) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    @(negedge clk_i);
    check_value("done_o lasts one cycle", done_o, 0);
    for (int w = 0; w < MEM_BYTES / 4; w++) begin
      if (touched[w]) begin
        peek_addr = addr_t'(w * 4);
        #1;
        check_value($sformatf("memory word %h after flush", w * 4), peek_data,
                    shadow_word(addr_t'(w * 4)));
      end
    end
  endtask

  task automatic non_mem_pass();
    run_op(1'b0, 1'b0, 1'b0, 1'b1, SIZE_WORD, 32'h0, 32'h0, 5'd7);
    check_value("non-memory latency", last_cycles, 0);
    check_value("non-memory stall", last_stall, 0);
    check_value("non-memory write enable", last_reg_wr_en, 1);
    check_value("non-memory register", last_wr_reg, 7);
    run_op(1'b0, 1'b0, 1'b0, 1'b0, SIZE_WORD, 32'h4, 32'h0, 5'd19);
    check_value("non-memory write enable off", last_reg_wr_en, 0);
    check_value("non-memory register", last_wr_reg, 19);
  endtask

  task automatic word_load_hit();
    load_and_check(SIZE_WORD, 32'h40, 1'b0);
    check_value("cold load misses", last_cycles != 0, 1);
    load_and_check(SIZE_WORD, 32'h44, 1'b0);
    check_value("same-line load hits", last_cycles, 0);
  endtask

  task automatic sub_word_access();
    store_and_update(SIZE_BYTE, 32'h90, 32'hdead_be81); // upper bits must be ignored
    store_and_update(SIZE_BYTE, 32'h91, 32'h1234_567f);
    store_and_update(SIZE_BYTE, 32'h92, 32'h0000_00c3);
    store_and_update(SIZE_BYTE, 32'h93, 32'hffff_ff05);
    store_and_update(SIZE_HALF, 32'h94, 32'hcafe_8001);
    store_and_update(SIZE_HALF, 32'h96, 32'h0000_7ffe);
    for (int k = 0; k < 8; k++) begin
      load_and_check(SIZE_BYTE, addr_t'(32'h90 + k), 1'b0);
      load_and_check(SIZE_BYTE, addr_t'(32'h90 + k), 1'b1);
    end
    for (int k = 0; k < 8; k += 2) begin
      load_and_check(SIZE_HALF, addr_t'(32'h90 + k), 1'b0);
      load_and_check(SIZE_HALF, addr_t'(32'h90 + k), 1'b1);
    end
    load_and_check(SIZE_WORD, 32'h90, 1'b0);
    load_and_check(SIZE_WORD, 32'h94, 1'b1);
  endtask

  // 0x120 and 0x160 share a cache index
  task automatic conflict_eviction();
    store_and_update(SIZE_WORD, 32'h120, 32'h1234_5678);
    store_and_update(SIZE_BYTE, 32'h12b, 32'h0000_00a9);
    load_and_check(SIZE_WORD, 32'h160, 1'b0);
    check_value("dirty victim written before fill", last_evict, 1);
    load_and_check(SIZE_WORD, 32'h120, 1'b0);
    load_and_check(SIZE_BYTE, 32'h12b, 1'b0);
  endtask

  task automatic flush_writeback();
    store_and_update(SIZE_WORD, 32'h1f0, 32'h0bad_f00d);
    store_and_update(SIZE_HALF, 32'h1e2, 32'h0000_c0de);
    flush_and_compare();
  endtask

  task automatic random_traffic();
    logic [31:0]  r;
    access_size_t sz;
    addr_t        a;
    for (int n = 0; n < RAND_OPS; n++) begin
      r  = lcg_next();
      sz = (r[31:30] == 2'd3) ? SIZE_WORD : access_size_t'(r[31:30]);
      a  = addr_t'(32'h200 | r[27:20]);
      if (sz == SIZE_HALF) begin
        a[0] = 1'b0;
      end else if (sz == SIZE_WORD) begin
        a[1:0] = 2'b00;
      end
      if (r[29]) begin
        store_and_update(sz, a, lcg_next());
      end else begin
        load_and_check(sz, a, r[28]);
      end
    end
  endtask

  initial begin
    word_t w;
    valid_i       = 1'b0;
    is_load_i     = 1'b0;
    is_store_i    = 1'b0;
    is_unsigned_i = 1'b0;
    reg_wr_en_i   = 1'b0;
    access_size_i = SIZE_WORD;
    addr_i        = '0;
    store_data_i  = '0;
    wr_reg_i      = '0;
    flush_i       = 1'b0;
    peek_addr     = '0;
    rst_i         = 1'b0;
    error_count   = 0;
    check_count   = 0;
    lcg_state     = SEED;
    for (int i = 0; i < MEM_BYTES; i++) begin
      w              = word_t'(i - i % 4) ^ FILL_KEY;
      shadow[i]      = w[(i % 4) * 8 +: 8];
      touched[i / 4] = 1'b0;
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    rst_i = 1'b1;
    @(negedge clk_i);
    check_value("outputs idle after reset",
                {stall_o, wb_valid_o, wb_reg_wr_en_o, rd_req_valid_o, wr_req_valid_o, done_o}, 0);
    repeat (2) @(posedge clk_i); // stage leaves IDLE

    non_mem_pass();
    word_load_hit();
    sub_word_access();
    conflict_eviction();
    flush_writeback();
    random_traffic();
    flush_and_compare();

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule : tb_lsu

// ==== test/line_mem_model.sv ====
`timescale 1ns/1ps

`include "lsu_defines.svh"

module line_mem_model #(
  parameter int          N_LINES    = `LSU_N_LINES,
  parameter int          LINE_BYTES = `LSU_LINE_BYTES,
  parameter int          MEM_BYTES  = 1024,
  parameter int          GNT_LAT    = 1,
  parameter int          RD_LAT     = 2,
  parameter int          WR_LAT     = 2,
  parameter logic [31:0] FILL_KEY   = 32'h0
)(
  input  logic           clk_i,
  input  logic           rst_i,

  input  logic           rd_req_i,
  input  logic           wr_req_i,
  input  lsu_pkg::addr_t addr_i,
  input  lsu_pkg::line_t wr_line_i,
  output logic           gnt_o,
  output logic           rvalid_o,
  output lsu_pkg::line_t line_o,
  output logic           write_done_o,

  // side port for checking memory contents
  input  lsu_pkg::addr_t peek_addr_i,
  output lsu_pkg::word_t peek_data_o
);

  import lsu_pkg::*;

  localparam int WORD_BITS      = `LSU_DATA_W;
  localparam int WORD_BYTES     = WORD_BITS / 8;
  localparam int WORDS_PER_LINE = LINE_BYTES / WORD_BYTES;
  localparam int MEM_WORDS      = MEM_BYTES / WORD_BYTES;

  word_t mem [MEM_WORDS];

  logic  busy_q;
  logic  is_wr_q;
  addr_t addr_q;
  line_t line_q; // write data taken at grant
  int    wait_q;

  function automatic int word_index(input addr_t a);
    return (a % MEM_BYTES) / WORD_BYTES;
  endfunction

  initial begin
    for (int k = 0; k < MEM_WORDS; k++) begin
      mem[k] = word_t'(k * WORD_BYTES) ^ FILL_KEY; // pattern from the full byte address
    end
  end

  assign peek_data_o = mem[word_index(peek_addr_i)];

  always @(posedge clk_i) begin
    if (!rst_i) begin
      gnt_o        <= 1'b0;
      rvalid_o     <= 1'b0;
      write_done_o <= 1'b0;
      line_o       <= '0;
      busy_q       <= 1'b0;
      is_wr_q      <= 1'b0;
      addr_q       <= '0;
      line_q       <= '0;
      wait_q       <= 0;
    end else begin
      gnt_o        <= 1'b0;
      rvalid_o     <= 1'b0;
      write_done_o <= 1'b0;
      if (!busy_q) begin
        if (rd_req_i || wr_req_i) begin
          if (wait_q == GNT_LAT) begin
            gnt_o   <= 1'b1;
            busy_q  <= 1'b1;
            is_wr_q <= wr_req_i;
            addr_q  <= addr_i;
            line_q  <= wr_line_i;
            wait_q  <= 0;
          end else begin
            wait_q <= wait_q + 1;
          end
        end
      end else if (wait_q == (is_wr_q ? WR_LAT : RD_LAT)) begin
        busy_q <= 1'b0;
        wait_q <= 0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
          if (is_wr_q) begin
            mem[word_index(addr_q) + w] <= line_q[w*WORD_BITS +: WORD_BITS];
          end else begin
            line_o[w*WORD_BITS +: WORD_BITS] <= mem[word_index(addr_q) + w];
          end
        end
        write_done_o <= is_wr_q;
        rvalid_o     <= !is_wr_q;
      end else begin
        wait_q <= wait_q + 1;
      end
    end
  end

endmodule : line_mem_model

// ==== hdl/lsu_top.sv ====
`timescale 1ns/1ps

module lsu_top (
  input  logic                  clk_i,
  input  logic                  rst_i,

  // from execute
  input  logic                  valid_i,
  input  logic                  is_load_i,
  input  logic                  is_store_i,
  input  logic                  is_unsigned_i,
  input  logic                  reg_wr_en_i,
  input  lsu_pkg::access_size_t access_size_i,
  input  lsu_pkg::addr_t        addr_i,
  input  lsu_pkg::word_t        store_data_i,
  input  lsu_pkg::reg_idx_t     wr_reg_i,

  // to writeback
  output logic                  stall_o,
  output logic                  wb_valid_o,
  output logic                  wb_reg_wr_en_o,
  output lsu_pkg::reg_idx_t     wb_wr_reg_o,
  output lsu_pkg::word_t        wb_data_o,

  // line port to backing memory
  output logic                  rd_req_valid_o,
  output logic                  wr_req_valid_o,
  output lsu_pkg::addr_t        mem_addr_o,
  output lsu_pkg::line_t        wr_line_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  lsu_pkg::line_t        mem_line_i,
  input  logic                  mem_write_done_i,

  input  logic                  flush_i,
  output logic                  done_o
);

  import lsu_pkg::*;

  logic  cache_req;
  logic  cache_wr;
  logic  cache_hit;
  logic  cache_rvalid;
  word_t cache_rdata;
  word_t cache_wdata;
  strb_t cache_wstrb;

  access_decode i_access_decode (
    .access_size_i (access_size_i),
    .addr_i        (addr_i),
    .store_data_i  (store_data_i),
    .wstrb_o       (cache_wstrb),
    .wdata_o       (cache_wdata)
  );

  mem_stage i_mem_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .valid_i        (valid_i),
    .is_load_i      (is_load_i),
    .is_store_i     (is_store_i),
    .reg_wr_en_i    (reg_wr_en_i),
    .cache_hit_i    (cache_hit),
    .cache_rvalid_i (cache_rvalid),
    .cache_req_o    (cache_req),
    .cache_wr_o     (cache_wr),
    .stall_o        (stall_o),
    .wb_valid_o     (wb_valid_o),
    .wb_reg_wr_en_o (wb_reg_wr_en_o)
  );

  data_cache i_data_cache (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_i            (cache_req),
    .wr_i             (cache_wr),
    .addr_i           (addr_i),
    .wdata_i          (cache_wdata),
    .wstrb_i          (cache_wstrb),
    .hit_o            (cache_hit),
    .rvalid_o         (cache_rvalid),
    .rdata_o          (cache_rdata),
    .rd_req_valid_o   (rd_req_valid_o),
    .wr_req_valid_o   (wr_req_valid_o),
    .mem_addr_o       (mem_addr_o),
    .wr_line_o        (wr_line_o),
    .mem_gnt_i        (mem_gnt_i),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_line_i       (mem_line_i),
    .mem_write_done_i (mem_write_done_i),
    .flush_i          (flush_i),
    .done_o           (done_o)
  );

  load_align i_load_align (
    .rdata_i       (cache_rdata),
    .addr_i        (addr_i),
    .access_size_i (access_size_i),
    .is_unsigned_i (is_unsigned_i),
    .data_o        (wb_data_o)
  );

  assign wb_wr_reg_o = wr_reg_i; // held by execute while stalled

endmodule : lsu_top

// ==== hdl/load_align.sv ====
`timescale 1ns/1ps

`include "lsu_defines.svh"

module load_align (
  input  lsu_pkg::word_t        rdata_i,
  input  lsu_pkg::addr_t        addr_i,
  input  lsu_pkg::access_size_t access_size_i,
  input  logic                  is_unsigned_i,
  output lsu_pkg::word_t        data_o
);

  import lsu_pkg::*;

  localparam int LANE_W = $clog2(`LSU_DATA_W / 8);

  word_t shifted;

  assign shifted = rdata_i >> {addr_i[LANE_W-1:0], 3'b000}; // addressed byte to bit 0

  always_comb begin
    case (access_size_i)
      SIZE_BYTE: begin
        data_o = {{(`LSU_DATA_W-8){shifted[7] & !is_unsigned_i}}, shifted[7:0]};
      end
      SIZE_HALF: begin
        data_o = {{(`LSU_DATA_W-16){shifted[15] & !is_unsigned_i}}, shifted[15:0]};
      end
      SIZE_WORD: begin
        data_o = shifted;
      end
      default: begin
        data_o = shifted;
      end
    endcase
  end

endmodule : load_align

// ==== hdl/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
  input  logic clk_i,
  input  logic rst_i,

  input  logic valid_i,
  input  logic is_load_i,
  input  logic is_store_i,
  input  logic reg_wr_en_i,

  input  logic cache_hit_i,
  input  logic cache_rvalid_i,
  output logic cache_req_o,
  output logic cache_wr_o,

  output logic stall_o,
  output logic wb_valid_o,
  output logic wb_reg_wr_en_o
);

  import lsu_pkg::*;

  stage_state_t state_q, state_d;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d        = state_q;
    cache_req_o    = 1'b0;
    cache_wr_o     = 1'b0;
    stall_o        = 1'b0;
    wb_valid_o     = 1'b0;
    wb_reg_wr_en_o = 1'b0;

    case (state_q)
      IDLE: begin
        state_d = READY; // one settle cycle after reset
      end
      READY: begin
        if (valid_i) begin
          cache_req_o = is_load_i | is_store_i;
          cache_wr_o  = is_store_i;
          if (is_load_i || is_store_i) begin
            if (cache_hit_i) begin
              wb_valid_o     = 1'b1;
              wb_reg_wr_en_o = is_load_i ? 1'b1 : reg_wr_en_i;
            end else begin
              stall_o = 1'b1; // cache starts its refill on this request
              state_d = WAITING;
            end
          end else begin
            wb_valid_o     = 1'b1;
            wb_reg_wr_en_o = reg_wr_en_i;
          end
        end
      end
      WAITING: begin
        stall_o = 1'b1;
        if (cache_rvalid_i && is_load_i) begin
          wb_valid_o     = 1'b1;
          wb_reg_wr_en_o = 1'b1;
          stall_o        = 1'b0;
          state_d        = READY;
        end else if (cache_hit_i && is_store_i) begin
          // line now resident, do the store write
          cache_req_o    = 1'b1;
          cache_wr_o     = 1'b1;
          wb_valid_o     = 1'b1;
          wb_reg_wr_en_o = reg_wr_en_i;
          stall_o        = 1'b0;
          state_d        = READY;
        end
      end
      default: state_d = IDLE;
    endcase
  end

endmodule : mem_stage

// ==== hdl/data_cache.sv ====
`timescale 1ns/1ps

`include "lsu_defines.svh"

module data_cache #(
  parameter int N_LINES    = `LSU_N_LINES,
  parameter int LINE_BYTES = `LSU_LINE_BYTES
)(
  input  logic           clk_i,
  input  logic           rst_i,

  input  logic           req_i,
  input  logic           wr_i,
  input  lsu_pkg::addr_t addr_i,
  input  lsu_pkg::word_t wdata_i,
  input  lsu_pkg::strb_t wstrb_i,
  output logic           hit_o,
  output logic           rvalid_o,
  output lsu_pkg::word_t rdata_o,

  output logic           rd_req_valid_o,
  output logic           wr_req_valid_o,
  output lsu_pkg::addr_t mem_addr_o,
  output lsu_pkg::line_t wr_line_o,
  input  logic           mem_gnt_i,
  input  logic           mem_rvalid_i,
  input  lsu_pkg::line_t mem_line_i,
  input  logic           mem_write_done_i,

  input  logic           flush_i,
  output logic           done_o
);

  import lsu_pkg::*;

  localparam int WORD_BITS = `LSU_DATA_W;
  localparam int STRB_W    = WORD_BITS / 8;
  localparam int OFF_W     = $clog2(LINE_BYTES);
  localparam int IDX_W     = $clog2(N_LINES);
  localparam int WSEL_W    = OFF_W - $clog2(STRB_W);
  localparam int TAG_W     = `LSU_ADDR_W - IDX_W - OFF_W;

  cache_state_t state_q, state_d;

  line_t            data_q [N_LINES];
  logic [TAG_W-1:0] tag_q  [N_LINES];
  logic [N_LINES-1:0] valid_q;
  logic [N_LINES-1:0] dirty_q;

  logic [IDX_W-1:0]  flush_idx_q;
  logic              flush_ack_q; // flush finished, wait for flush_i to drop
  logic              rvalid_q;
  logic              done_q;

  logic [TAG_W-1:0]  req_tag;
  logic [IDX_W-1:0]  req_idx;
  logic [WSEL_W-1:0] req_wsel;
  logic [IDX_W-1:0]  sel_idx;
  logic              flush_phase;
  logic              flush_last;
  logic              store_hit;
  logic              fill_done;
  logic              wb_done;
  logic              flush_step;
  logic              flush_end;

  assign req_tag  = addr_i[`LSU_ADDR_W-1 -: TAG_W];
  assign req_idx  = addr_i[OFF_W +: IDX_W];
  assign req_wsel = addr_i[OFF_W-1 -: WSEL_W];

  assign hit_o    = valid_q[req_idx] && (tag_q[req_idx] == req_tag);
  assign rdata_o  = data_q[req_idx][int'(req_wsel) * WORD_BITS +: WORD_BITS];
  assign rvalid_o = rvalid_q;
  assign done_o   = done_q;

  assign flush_phase = (state_q == C_FLUSH) || (state_q == C_FLUSH_WAIT);
  assign flush_last  = (flush_idx_q == IDX_W'(N_LINES - 1));
  assign sel_idx     = flush_phase ? flush_idx_q : req_idx; // line being written back
  assign store_hit   = (state_q == C_IDLE) && req_i && wr_i && hit_o;

  // memory side request levels
  assign rd_req_valid_o = (state_q == C_FILL);
  assign wr_req_valid_o = (state_q == C_EVICT) ||
                          ((state_q == C_FLUSH) && dirty_q[flush_idx_q]);
  assign wr_line_o      = data_q[sel_idx];

  always_comb begin
    if ((state_q == C_FILL) || (state_q == C_FILL_WAIT)) begin
      mem_addr_o = {req_tag, req_idx, {OFF_W{1'b0}}};
    end else begin
      mem_addr_o = {tag_q[sel_idx], sel_idx, {OFF_W{1'b0}}};
    end
  end

  always_comb begin
    state_d    = state_q;
    fill_done  = 1'b0;
    wb_done    = 1'b0;
    flush_step = 1'b0;
    flush_end  = 1'b0;

    case (state_q)
      C_IDLE: begin
        if (req_i && !hit_o) begin
          state_d = dirty_q[req_idx] ? C_EVICT : C_FILL;
        end else if (flush_i && !flush_ack_q) begin
          state_d = C_FLUSH;
        end
      end
      C_EVICT: begin
        if (mem_gnt_i) begin
          state_d = C_EVICT_WAIT;
        end
      end
      C_EVICT_WAIT: begin
        if (mem_write_done_i) begin
          wb_done = 1'b1;
          state_d = C_FILL;
        end
      end
      C_FILL: begin
        if (mem_gnt_i) begin
          state_d = C_FILL_WAIT;
        end
      end
      C_FILL_WAIT: begin
        if (mem_rvalid_i) begin
          fill_done = 1'b1;
          state_d   = C_IDLE;
        end
      end
      C_FLUSH: begin
        if (dirty_q[flush_idx_q]) begin
          if (mem_gnt_i) begin
            state_d = C_FLUSH_WAIT;
          end
        end else begin
          flush_step = 1'b1; // clean line, skip
          if (flush_last) begin
            flush_end = 1'b1;
            state_d   = C_IDLE;
          end
        end
      end
      C_FLUSH_WAIT: begin
        if (mem_write_done_i) begin
          wb_done    = 1'b1;
          flush_step = 1'b1;
          flush_end  = flush_last;
          state_d    = flush_last ? C_IDLE : C_FLUSH;
        end
      end
      default: state_d = C_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      state_q     <= C_IDLE;
      valid_q     <= '0;
      dirty_q     <= '0;
      flush_idx_q <= '0;
      flush_ack_q <= 1'b0;
      rvalid_q    <= 1'b0;
      done_q      <= 1'b0;
    end else begin
      state_q  <= state_d;
      rvalid_q <= fill_done; // line is in the array when this pulses
      done_q   <= flush_end;
      if (flush_end) begin
        flush_ack_q <= 1'b1;
      end else if (!flush_i) begin
        flush_ack_q <= 1'b0;
      end
      if (flush_step) begin
        flush_idx_q <= flush_idx_q + 1'b1; // wraps to 0 after the last line
      end
      if (wb_done) begin
        dirty_q[sel_idx] <= 1'b0;
      end
      if (fill_done) begin
        valid_q[req_idx] <= 1'b1;
        dirty_q[req_idx] <= 1'b0;
      end
      if (store_hit) begin
        dirty_q[req_idx] <= 1'b1;
      end
    end
  end

  // line data and tags
  always_ff @(posedge clk_i) begin
    if (fill_done) begin
      data_q[req_idx] <= mem_line_i;
      tag_q[req_idx]  <= req_tag;
    end else if (store_hit) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wstrb_i[b]) begin
          data_q[req_idx][int'(req_wsel) * WORD_BITS + b * 8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

endmodule : data_cache

// ==== hdl/access_decode.sv ====
`timescale 1ns/1ps

`include "lsu_defines.svh"

module access_decode (
  input  lsu_pkg::access_size_t access_size_i,
  input  lsu_pkg::addr_t        addr_i,
  input  lsu_pkg::word_t        store_data_i,
  output lsu_pkg::strb_t        wstrb_o,
  output lsu_pkg::word_t        wdata_o
);

  import lsu_pkg::*;

  localparam int LANES  = `LSU_DATA_W / 8;
  localparam int LANE_W = $clog2(LANES);

  strb_t base_strb;

  always_comb begin
    case (access_size_i)
      SIZE_BYTE: begin
        base_strb = strb_t'(1);
        wdata_o   = {LANES{store_data_i[7:0]}}; // byte copied into every lane
      end
      SIZE_HALF: begin
        base_strb = strb_t'(3);
        wdata_o   = {(LANES/2){store_data_i[15:0]}};
      end
      SIZE_WORD: begin
        base_strb = '1;
        wdata_o   = store_data_i;
      end
      default: begin
        base_strb = '1;
        wdata_o   = store_data_i;
      end
    endcase
  end

  // move the enables onto the addressed lanes
  assign wstrb_o = base_strb << addr_i[LANE_W-1:0];

endmodule : access_decode

// ==== hdl/lsu_pkg.sv ====
`include "lsu_defines.svh"

package lsu_pkg;

  typedef logic [`LSU_ADDR_W-1:0]     addr_t;
  typedef logic [`LSU_DATA_W-1:0]     word_t;
  typedef logic [`LSU_REG_W-1:0]      reg_idx_t;
  typedef logic [`LSU_DATA_W/8-1:0]   strb_t;   // one enable per byte lane
  typedef logic [`LSU_LINE_BYTES*8-1:0] line_t;

  // load/store access size as encoded by execute
  typedef logic [1:0] access_size_t;

  localparam access_size_t SIZE_BYTE = 2'b00;
  localparam access_size_t SIZE_HALF = 2'b01;
  localparam access_size_t SIZE_WORD = 2'b10;

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    READY   = 2'b01,
    WAITING = 2'b10
  } stage_state_t;

  typedef enum logic [2:0] {
    C_IDLE       = 3'd0,
    C_EVICT      = 3'd1, // victim write requested
    C_EVICT_WAIT = 3'd2,
    C_FILL       = 3'd3, // line read requested
    C_FILL_WAIT  = 3'd4,
    C_FLUSH      = 3'd5,
    C_FLUSH_WAIT = 3'd6
  } cache_state_t;

endpackage : lsu_pkg

// ==== hdl/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// pipeline widths
`define LSU_ADDR_W 32 // byte address
`define LSU_DATA_W 32 // data word
`define LSU_REG_W 5   // register index

// data cache geometry
`define LSU_LINE_BYTES 16 // power of two
`define LSU_N_LINES 4     // power of two, direct mapped

`endif
